/* common/cachePkg.sv */
// shared cache types; geometry fixed at 32-bit words, 2 ways, 64 sets, 64-byte lines
package cachePkg;

	// geometry
	localparam int addrWidth = 32;
	localparam int wordWidth = 32;
	localparam int numSets = 64;
	localparam int numWays = 2;
	localparam int wordsPerLine = 16;
	localparam int offsetBits = 6; // byte offset within a line
	localparam int indexBits = 6;
	localparam int tagBits = addrWidth - indexBits - offsetBits;
	localparam int lineWidth = wordsPerLine * wordWidth;
	localparam int wordSelBits = $clog2(wordsPerLine);
	localparam int byteSelBits = offsetBits - wordSelBits;

	// address fields, msb first
	typedef struct packed {
		logic [tagBits-1:0] tag;
		logic [indexBits-1:0] index;
		logic [wordSelBits-1:0] wordSel;
		logic [byteSelBits-1:0] byteSel;
	} addrParts_t;

	typedef enum logic {
		opRead,
		opWrite
	} cpuOp_t;

	// one cpu access
	typedef struct packed {
		cpuOp_t op;
		logic [addrWidth-1:0] addr;
		logic [wordWidth-1:0] wdata; // ignored on reads
	} cpuReq_t;

	// line-aligned address with full line payload, fill or write-back
	typedef struct packed {
		logic [addrWidth-1:0] addr;
		logic [lineWidth-1:0] line;
	} memLine_t;

	// miss handling
	typedef enum logic [1:0] {
		stIdle,
		stWriteBack,
		stFill
	} ctrlState_t;

	typedef logic way_t;

endpackage

/* cache/dataStore.sv */
// line data array; async read, line write takes priority over word write
`timescale 1ns/1ps

module dataStore (
	input logic clk,
	input logic [cachePkg::addrWidth-1:0] lookupAddr,
	input cachePkg::way_t way,
	input logic wordWe,
	input logic [cachePkg::wordWidth-1:0] wdata,
	output logic [cachePkg::wordWidth-1:0] wordRd,
	input logic lineWe,
	input logic [cachePkg::lineWidth-1:0] lineIn,
	output logic [cachePkg::lineWidth-1:0] victimLine
);
	import cachePkg::*;

	localparam int slotBits = $clog2(numWays) + indexBits;

	addrParts_t parts;
	logic [lineWidth-1:0] lines [numWays*numSets];
	logic [slotBits-1:0] slot; // way and set together

	assign parts = addrParts_t'(lookupAddr);
	assign slot = {way, parts.index};

	assign victimLine = lines[slot];
	assign wordRd = victimLine[parts.wordSel*wordWidth +: wordWidth];

	always_ff @(posedge clk) begin
		if (lineWe)
			lines[slot] <= lineIn;
		else if (wordWe)
			lines[slot][parts.wordSel*wordWidth +: wordWidth] <= wdata;
	end

endmodule

/* cache/tagStore.sv */
// tags plus valid/dirty/LRU per set; LRU way is always the victim, invalid or not
`timescale 1ns/1ps

module tagStore (
	input logic clk,
	input logic reset,
	input logic [cachePkg::addrWidth-1:0] lookupAddr,
	output logic hit,
	output cachePkg::way_t hitWay,
	output cachePkg::way_t victimWay,
	output logic victimDirty,
	output logic [cachePkg::tagBits-1:0] victimTag,
	input logic touch,
	input logic setDirty,
	input logic fillEn,
	input logic invalEn,
	input cachePkg::way_t way
);
	import cachePkg::*;

	addrParts_t parts;
	logic [tagBits-1:0] tags [numWays][numSets];
	logic [numSets-1:0] valid [numWays];
	logic [numSets-1:0] dirty [numWays];
	logic [numSets-1:0] lru; // per set, the least recently used way
	logic [numWays-1:0] wayHit;

	assign parts = addrParts_t'(lookupAddr);

	// compare both ways
	always_comb begin
		for (int w = 0; w < numWays; w++)
			wayHit[w] = valid[w][parts.index] && (tags[w][parts.index] == parts.tag);
	end

	assign hit = |wayHit;
	assign hitWay = wayHit[1];

	assign victimWay = lru[parts.index];
	assign victimDirty = valid[victimWay][parts.index] && dirty[victimWay][parts.index];
	assign victimTag = tags[victimWay][parts.index];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < numWays; w++) begin
				valid[w] <= '0;
				dirty[w] <= '0;
			end
			lru <= '0; // way 0 goes first
		end else if (invalEn) begin
			if (hit) begin
				valid[hitWay][parts.index] <= 1'b0;
				dirty[hitWay][parts.index] <= 1'b0; // modified data is dropped
			end
		end else if (fillEn) begin
			valid[way][parts.index] <= 1'b1;
			dirty[way][parts.index] <= 1'b0;
			lru[parts.index] <= ~way;
		end else begin
			if (touch)
				lru[parts.index] <= ~way; // other way becomes LRU
			if (setDirty)
				dirty[way][parts.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fillEn)
			tags[way][parts.index] <= parts.tag;
	end

endmodule

/* cache/cacheController.sv */
// miss FSM; req ignored while busy or under inval, inval only honoured when not busy
`timescale 1ns/1ps

module cacheController (
	input logic clk,
	input logic reset,
	// cpu side
	input logic req,
	input cachePkg::cpuReq_t cpuReq,
	output logic busy,
	output logic respValid,
	output logic [cachePkg::wordWidth-1:0] rdata,
	input logic inval,
	input logic [cachePkg::addrWidth-1:0] invalAddr,
	// tag store
	output logic [cachePkg::addrWidth-1:0] lookupAddr,
	input logic hit,
	input cachePkg::way_t hitWay,
	input cachePkg::way_t victimWay,
	input logic victimDirty,
	input logic [cachePkg::tagBits-1:0] victimTag,
	output logic touch,
	output logic setDirty,
	output logic fillEn,
	output logic invalEn,
	output cachePkg::way_t wayOut,
	// data store
	output logic wordWe,
	output logic lineWe,
	output logic [cachePkg::wordWidth-1:0] wdata,
	input logic [cachePkg::wordWidth-1:0] wordRd,
	input logic [cachePkg::lineWidth-1:0] victimLine,
	// memory
	output logic fillReq,
	output logic [cachePkg::addrWidth-1:0] fillAddr,
	input logic fillValid,
	output logic wbReq,
	output cachePkg::memLine_t wbLine,
	input logic wbDone
);
	import cachePkg::*;

	ctrlState_t state;
	cpuReq_t held; // accepted request, replayed after a fill
	addrParts_t heldParts;
	logic pending;
	logic accept;
	logic lookup;
	way_t victimReg;

	assign heldParts = addrParts_t'(held.addr);

	assign busy = pending || (state != stIdle);
	assign invalEn = inval && !busy; // wins over req
	assign accept = req && !busy && !inval;
	assign lookup = pending && (state == stIdle);

	assign lookupAddr = invalEn ? invalAddr : held.addr;

	// hit: word access and LRU update in the lookup cycle
	assign touch = lookup && hit;
	assign setDirty = touch && (held.op == opWrite);
	assign wordWe = setDirty;
	assign wdata = held.wdata;

	// fill writes tag and line into the latched victim way
	assign fillEn = (state == stFill) && fillValid;
	assign lineWe = fillEn;

	always_comb begin
		if (state == stFill)
			wayOut = victimReg;
		else if (hit)
			wayOut = hitWay;
		else
			wayOut = victimWay; // miss lookup reads out the victim line
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			pending <= 1'b0;
			respValid <= 1'b0;
			fillReq <= 1'b0;
			wbReq <= 1'b0;
		end else begin
			respValid <= 1'b0;
			fillReq <= 1'b0;
			wbReq <= 1'b0;
			case (state)
				stIdle: begin
					if (accept) begin
						pending <= 1'b1;
					end else if (lookup) begin
						if (hit) begin
							respValid <= 1'b1;
							pending <= 1'b0;
						end else if (victimDirty) begin
							wbReq <= 1'b1;
							state <= stWriteBack;
						end else begin
							fillReq <= 1'b1;
							state <= stFill;
						end
					end
				end
				stWriteBack: begin
					if (wbDone) begin
						fillReq <= 1'b1;
						state <= stFill;
					end
				end
				stFill: begin
					if (fillValid)
						state <= stIdle; // pending still set, replays as a hit
				end
				default: state <= stIdle;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (accept)
			held <= cpuReq;
		if (lookup) begin
			rdata <= wordRd;
			victimReg <= victimWay;
			fillAddr <= {heldParts.tag, heldParts.index, {offsetBits{1'b0}}};
			// old line goes back to its own address
			wbLine.addr <= {victimTag, heldParts.index, {offsetBits{1'b0}}};
			wbLine.line <= victimLine;
		end
	end

endmodule

/* cache/cacheTop.sv */
// 2-way write-back data cache; one memory request outstanding, invalidate drops dirty data
`timescale 1ns/1ps

module cacheTop (
	input logic clk,
	input logic reset,
	// cpu port
	input logic req,
	input cachePkg::cpuReq_t cpuReq,
	output logic busy,
	output logic respValid,
	output logic [cachePkg::wordWidth-1:0] rdata,
	// invalidate
	input logic inval,
	input logic [cachePkg::addrWidth-1:0] invalAddr,
	// memory fill
	output logic fillReq,
	output logic [cachePkg::addrWidth-1:0] fillAddr,
	input logic fillValid,
	input logic [cachePkg::lineWidth-1:0] fillLine,
	// memory write-back
	output logic wbReq,
	output cachePkg::memLine_t wbLine,
	input logic wbDone
);
	import cachePkg::*;

	logic [addrWidth-1:0] lookupAddr;
	logic hit;
	way_t hitWay;
	way_t victimWay;
	logic victimDirty;
	logic [tagBits-1:0] victimTag;
	logic touch;
	logic setDirty;
	logic fillEn;
	logic invalEn;
	way_t way; // way the arrays act on this cycle
	logic wordWe;
	logic lineWe;
	logic [wordWidth-1:0] wordWr;
	logic [wordWidth-1:0] wordRd;
	logic [lineWidth-1:0] victimLine;

	cacheController cacheController_i (
		.clk(clk),
		.reset(reset),
		.req(req),
		.cpuReq(cpuReq),
		.busy(busy),
		.respValid(respValid),
		.rdata(rdata),
		.inval(inval),
		.invalAddr(invalAddr),
		.lookupAddr(lookupAddr),
		.hit(hit),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.touch(touch),
		.setDirty(setDirty),
		.fillEn(fillEn),
		.invalEn(invalEn),
		.wayOut(way),
		.wordWe(wordWe),
		.lineWe(lineWe),
		.wdata(wordWr),
		.wordRd(wordRd),
		.victimLine(victimLine),
		.fillReq(fillReq),
		.fillAddr(fillAddr),
		.fillValid(fillValid),
		.wbReq(wbReq),
		.wbLine(wbLine),
		.wbDone(wbDone)
	);

	tagStore tagStore_i (
		.clk(clk),
		.reset(reset),
		.lookupAddr(lookupAddr),
		.hit(hit),
		.hitWay(hitWay),
		.victimWay(victimWay),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.touch(touch),
		.setDirty(setDirty),
		.fillEn(fillEn),
		.invalEn(invalEn),
		.way(way)
	);

	dataStore dataStore_i (
		.clk(clk),
		.lookupAddr(lookupAddr),
		.way(way),
		.wordWe(wordWe),
		.wdata(wordWr),
		.wordRd(wordRd),
		.lineWe(lineWe),
		.lineIn(fillLine), // fill data lands straight in the array
		.victimLine(victimLine)
	);

endmodule

/* tb/cacheController_assert.sv */
// controller protocol properties are checked only outside reset
`timescale 1ns/1ps

module cacheControllerAssert (
	input logic clk,
	input logic reset,
	input cachePkg::ctrlState_t state,
	input logic pending,
	input logic respValid,
	input logic fillReq,
	input logic wbReq
);
	import cachePkg::*;

	// completion is a single pulse
	assert property (@(posedge clk) disable iff (reset) respValid |=> !respValid)
		else $error("respValid held for more than one cycle");

	assert property (@(posedge clk) disable iff (reset) !(fillReq && wbReq))
		else $error("fill and write-back requested together");

	// a miss always belongs to a held request that replays afterwards
	assert property (@(posedge clk) disable iff (reset) (state != stIdle) |-> pending)
		else $error("miss in progress without a held request to replay");

endmodule

bind cacheController cacheControllerAssert cacheControllerAssert_i (
	.clk(clk),
	.reset(reset),
	.state(state),
	.pending(pending),
	.respValid(respValid),
	.fillReq(fillReq),
	.wbReq(wbReq)
);

/* tb/cacheTb.sv */
// table-driven cache test; memory answers fills after 4 cycles and write-backs after 3
`timescale 1ns/1ps

module cacheTb;
	import cachePkg::*;

	typedef enum {kRead, kWrite, kInval} rowKind_t;
	typedef enum {noTraffic, fillOnly, wbThenFill} traffic_t;

	typedef struct {
		string name;
		rowKind_t kind;
		logic [addrWidth-1:0] addr;
		traffic_t traffic;
		logic [addrWidth-1:0] wbAddr; // only used with wbThenFill
	} testRow_t;

	logic clk;
	logic reset;
	logic req;
	cpuReq_t cpuReq;
	logic busy;
	logic respValid;
	logic [wordWidth-1:0] rdata;
	logic inval;
	logic [addrWidth-1:0] invalAddr;
	logic fillReq;
	logic [addrWidth-1:0] fillAddr;
	logic fillValid;
	logic [lineWidth-1:0] fillLine;
	logic wbReq;
	memLine_t wbLine;
	logic wbDone;

	testRow_t tests[$];
	bit tableReady;
	int errorCount;
	int checkCount;

	// traffic seen during the current row
	int fillCount;
	int wbCount;
	bit wbFirst;
	logic [addrWidth-1:0] fillAddrSeen;
	logic [addrWidth-1:0] wbAddrSeen;
	logic [lineWidth-1:0] wbDataSeen;

	logic [lineWidth-1:0] memLines [bit [31:0]]; // written-back lines by line address
	logic [wordWidth-1:0] refMem [bit [31:0]]; // what the cpu should see
	logic [wordWidth-1:0] refBacking [bit [31:0]]; // what memory should hold

	cacheTop cacheTop_i (
		.clk(clk),
		.reset(reset),
		.req(req),
		.cpuReq(cpuReq),
		.busy(busy),
		.respValid(respValid),
		.rdata(rdata),
		.inval(inval),
		.invalAddr(invalAddr),
		.fillReq(fillReq),
		.fillAddr(fillAddr),
		.fillValid(fillValid),
		.fillLine(fillLine),
		.wbReq(wbReq),
		.wbLine(wbLine),
		.wbDone(wbDone)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [lineWidth-1:0] memRead(logic [addrWidth-1:0] lineAddr);
		logic [lineWidth-1:0] line;
		if (memLines.exists(lineAddr))
			return memLines[lineAddr];
		for (int i = 0; i < wordsPerLine; i++)
			line[i*wordWidth +: wordWidth] = lineAddr + 4 * i; // byte address pattern
		return line;
	endfunction

	function automatic logic [wordWidth-1:0] refRead(logic [addrWidth-1:0] wordAddr);
		return refMem.exists(wordAddr) ? refMem[wordAddr] : wordAddr;
	endfunction

	function automatic logic [wordWidth-1:0] backingRead(logic [addrWidth-1:0] wordAddr);
		return refBacking.exists(wordAddr) ? refBacking[wordAddr] : wordAddr;
	endfunction

	function automatic void addRow(string name, rowKind_t kind, logic [addrWidth-1:0] addr,
			traffic_t traffic, logic [addrWidth-1:0] wbAddr);
		testRow_t row;
		row.name = name;
		row.kind = kind;
		row.addr = addr;
		row.traffic = traffic;
		row.wbAddr = wbAddr;
		tests.push_back(row);
	endfunction

	task automatic checkValue(string testName, string what, logic [31:0] expected,
			logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("mismatch %s %s: expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkTrue(bit cond, string testName, string msg);
		checkCount++;
		assert (cond) else begin
			errorCount++;
			$display("%s: %s", testName, msg);
		end
	endtask

	// memory model serving one request at a time
	initial begin : memoryModel
		logic [addrWidth-1:0] reqAddr;
		forever begin
			@(posedge clk);
			if (fillReq) begin
				reqAddr = fillAddr;
				repeat (4) @(posedge clk);
				#1;
				fillLine = memRead(reqAddr);
				fillValid = 1'b1;
				@(posedge clk);
				#1;
				fillValid = 1'b0;
			end else if (wbReq) begin
				memLines[wbLine.addr] = wbLine.line;
				repeat (3) @(posedge clk);
				#1;
				wbDone = 1'b1;
				@(posedge clk);
				#1;
				wbDone = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (wbReq) begin
			wbCount++;
			wbAddrSeen = wbLine.addr;
			wbDataSeen = wbLine.line;
			if (fillCount == 0)
				wbFirst = 1'b1;
		end
		if (fillReq) begin
			fillCount++;
			fillAddrSeen = fillAddr;
		end
	end

	task automatic applyRow(testRow_t row);
		logic [addrWidth-1:0] wordAddr;
		logic [addrWidth-1:0] lineAddr;
		logic [wordWidth-1:0] wdata;
		int cycles;
		wordAddr = {row.addr[addrWidth-1:2], 2'b00};
		lineAddr = {row.addr[addrWidth-1:offsetBits], {offsetBits{1'b0}}};
		wdata = $urandom();
		@(posedge clk);
		#1;
		fillCount = 0;
		wbCount = 0;
		wbFirst = 1'b0;
		checkTrue(!busy, row.name, "cache still busy when the next request was due");
		if (row.kind == kInval) begin
			inval = 1'b1;
			invalAddr = row.addr;
			@(posedge clk);
			#1;
			inval = 1'b0;
			for (int i = 0; i < wordsPerLine; i++)
				refMem[lineAddr + 4 * i] = backingRead(lineAddr + 4 * i); // dirty data lost
			return;
		end
		req = 1'b1;
		cpuReq.op = (row.kind == kWrite) ? opWrite : opRead;
		cpuReq.addr = row.addr;
		cpuReq.wdata = wdata;
		@(posedge clk);
		#1;
		req = 1'b0;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!respValid);
		checkValue(row.name, "write-back requests", (row.traffic == wbThenFill) ? 1 : 0, wbCount);
		checkValue(row.name, "fill requests", (row.traffic == noTraffic) ? 0 : 1, fillCount);
		if (row.traffic == noTraffic)
			checkValue(row.name, "hit response cycles", 1, cycles);
		else
			checkValue(row.name, "fill address", lineAddr, fillAddrSeen);
		if (row.traffic == wbThenFill) begin
			checkTrue(wbFirst, row.name, "fill was requested before the write-back");
			checkValue(row.name, "write-back address", row.wbAddr, wbAddrSeen);
			for (int i = 0; i < wordsPerLine; i++) begin
				checkValue(row.name, "write-back word", refRead(row.wbAddr + 4 * i),
					wbDataSeen[i*wordWidth +: wordWidth]);
				refBacking[row.wbAddr + 4 * i] = refRead(row.wbAddr + 4 * i);
			end
		end
		if (row.kind == kWrite)
			refMem[wordAddr] = wdata;
		else
			checkValue(row.name, "rdata", refRead(wordAddr), rdata);
	endtask

	initial begin
		void'($urandom(32'hee970505));
		reset = 1'b1;
		req = 1'b0;
		cpuReq = '0;
		inval = 1'b0;
		invalAddr = '0;
		fillValid = 1'b0;
		fillLine = '0;
		wbDone = 1'b0;
		errorCount = 0;
		checkCount = 0;
		// lines A, B, C, D share set 5; E sits in set 9
		addRow("first read", kRead, 32'h0000_1148, fillOnly, '0);
		addRow("same line read", kRead, 32'h0000_117c, noTraffic, '0);
		addRow("write hit", kWrite, 32'h0000_117c, noTraffic, '0);
		addRow("read after write", kRead, 32'h0000_117c, noTraffic, '0);
		addRow("write miss", kWrite, 32'h0000_5250, fillOnly, '0);
		addRow("read write-miss word", kRead, 32'h0000_5250, noTraffic, '0);
		addRow("B fills way 1", kRead, 32'h0000_2144, fillOnly, '0);
		addRow("touch A", kRead, 32'h0000_1140, noTraffic, '0);
		addRow("C evicts B", kRead, 32'h0000_3160, fillOnly, '0);
		addRow("A still resident", kRead, 32'h0000_1148, noTraffic, '0);
		addRow("B fills again", kRead, 32'h0000_2144, fillOnly, '0);
		addRow("second write to A", kWrite, 32'h0000_1154, noTraffic, '0);
		addRow("touch B", kRead, 32'h0000_2148, noTraffic, '0);
		addRow("D evicts dirty A", kRead, 32'h0000_4140, wbThenFill, 32'h0000_1140);
		addRow("C evicts clean B", kRead, 32'h0000_3140, fillOnly, '0);
		addRow("A back from memory", kRead, 32'h0000_1154, fillOnly, '0);
		addRow("write before inval", kWrite, 32'h0000_1158, noTraffic, '0);
		addRow("touch C", kRead, 32'h0000_3144, noTraffic, '0); // A's way becomes the victim
		addRow("invalidate A", kInval, 32'h0000_1140, noTraffic, '0);
		addRow("read after inval", kRead, 32'h0000_1158, fillOnly, '0);
		addRow("written-back word", kRead, 32'h0000_1154, noTraffic, '0);
		tableReady = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		checkValue("reset", "busy", 0, busy);
		checkValue("reset", "respValid", 0, respValid);
		checkValue("reset", "fillReq", 0, fillReq);
		checkValue("reset", "wbReq", 0, wbReq);
		foreach (tests[i])
			applyRow(tests[i]);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		wait (tableReady);
		repeat (tests.size() * 64) @(posedge clk);
		$display("watchdog timeout, cache stopped responding");
		$display("test failed");
		$finish;
	end

endmodule

/* cacheTop.f */
common/cachePkg.sv
cache/dataStore.sv
cache/tagStore.sv
cache/cacheController.sv
cache/cacheTop.sv
tb/cacheController_assert.sv
tb/cacheTb.sv
